// ==== hw/game_view_top.sv ====
/* top of the frame drawing subsystem, connects placer, sequencer, the five rectangle
   painters and the Wishbone pixel writer */
module game_view_top import scene_pkg::*; (
	input  logic      clk,
	input  logic      resetn,
	input  logic      go,
	input  logic      game_end,
	input  coord_x_t  hook_x,
	input  coord_y_t  hook_y,
	output logic      frame_done,
	output logic      wb_cyc,
	output logic      wb_stb,
	output logic      wb_we,
	output pix_addr_t wb_adr,
	output colour_t   wb_dat_o,
	output logic      wb_sel,
	input  logic      wb_ack
);

	logic               place_req;
	logic               place_done;
	obj_kind_t          rd_kind;
	logic [1:0]         rd_index;
	coord_x_t           rd_x;
	coord_y_t           rd_y;
	logic [N_KINDS-1:0] paint_start;
	logic [N_KINDS-1:0] paint_done;
	coord_x_t           org_x;
	coord_y_t           org_y;
	logic [N_KINDS-1:0] pix_valid;
	logic [N_KINDS-1:0] pix_ready;
	pix_addr_t          pix_addr [N_KINDS];
	colour_t            pix_colour [N_KINDS];

	object_placer placer_i (
		.clk        (clk),
		.resetn     (resetn),
		.place_req  (place_req),
		.place_done (place_done),
		.rd_kind    (rd_kind),
		.rd_index   (rd_index),
		.rd_x       (rd_x),
		.rd_y       (rd_y)
	);

	scene_sequencer sequencer_i (
		.clk         (clk),
		.resetn      (resetn),
		.go          (go),
		.game_end    (game_end),
		.hook_x      (hook_x),
		.hook_y      (hook_y),
		.place_req   (place_req),
		.place_done  (place_done),
		.rd_kind     (rd_kind),
		.rd_index    (rd_index),
		.rd_x        (rd_x),
		.rd_y        (rd_y),
		.paint_start (paint_start),
		.org_x       (org_x),
		.org_y       (org_y),
		.paint_done  (paint_done),
		.frame_done  (frame_done)
	);

	// painter index equals its object kind
	for (genvar i = 0; i < N_KINDS; i++) begin : g_painter
		rect_painter #(.kind(obj_kind_t'(i))) painter_i (
			.clk        (clk),
			.resetn     (resetn),
			.start      (paint_start[i]),
			.org_x      (org_x),
			.org_y      (org_y),
			.done       (paint_done[i]),
			.pix_valid  (pix_valid[i]),
			.pix_addr   (pix_addr[i]),
			.pix_colour (pix_colour[i]),
			.pix_ready  (pix_ready[i])
		);
	end

	pixel_bus_master bus_master_i (
		.clk        (clk),
		.resetn     (resetn),
		.pix_valid  (pix_valid),
		.pix_addr   (pix_addr),
		.pix_colour (pix_colour),
		.pix_ready  (pix_ready),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_o   (wb_dat_o),
		.wb_sel     (wb_sel),
		.wb_ack     (wb_ack)
	);

endmodule

// ==== hw/object_placer.sv ====
/* picks random on-screen origins for the gold, stone and diamond objects after each
   place_req and serves them back by kind and index */
`include "scene_macros.svh"

module object_placer import scene_pkg::*; (
	input  logic      clk,
	input  logic      resetn,
	input  logic      place_req,
	output logic      place_done,
	input  obj_kind_t rd_kind,
	input  logic [1:0] rd_index,
	output coord_x_t  rd_x,
	output coord_y_t  rd_y
);

	localparam int n_obj = `N_GOLD + `N_STONE + `N_DIAMOND;
	localparam int base_stone = `N_GOLD;
	localparam int base_diamond = `N_GOLD + `N_STONE;

	typedef logic [$clog2(n_obj)-1:0] slot_t;

	logic [15:0] lfsr;
	logic        placing;
	slot_t       slot;	// next table entry to fill
	obj_kind_t   fill_kind;
	coord_x_t    cand_x;
	coord_y_t    cand_y;
	logic        fits;
	coord_x_t    tab_x [n_obj];
	coord_y_t    tab_y [n_obj];
	slot_t       rd_slot;
	logic        rd_hit;

	assign cand_x = lfsr[4:0];
	assign cand_y = lfsr[9:5];

	// table order is gold, stone, diamond
	always_comb begin
		if (slot < base_stone)
			fill_kind = KIND_GOLD;
		else if (slot < base_diamond)
			fill_kind = KIND_STONE;
		else
			fill_kind = KIND_DIAMOND;
	end

	// whole rectangle must stay on screen
	assign fits = ({1'b0, cand_x} + kind_width[fill_kind] <= dim_t'(`SCREEN_W)) &&
		({1'b0, cand_y} + kind_height[fill_kind] <= dim_t'(`SCREEN_H));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			lfsr <= `PLACE_SEED;
			placing <= 1'b0;
			place_done <= 1'b0;
			slot <= '0;
		end else begin
			place_done <= 1'b0;
			if (place_req) begin
				placing <= 1'b1;
				slot <= '0;
			end else if (placing) begin
				lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
				if (fits) begin
					slot <= slot + slot_t'(1);
					if (slot == slot_t'(n_obj - 1)) begin
						placing <= 1'b0;
						place_done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (placing && fits) begin
			tab_x[slot] <= cand_x;
			tab_y[slot] <= cand_y;
		end
	end

	always_comb begin
		rd_hit = 1'b1;
		case (rd_kind)
			KIND_GOLD:    rd_slot = slot_t'(rd_index);
			KIND_STONE:   rd_slot = slot_t'(base_stone + int'(rd_index));
			KIND_DIAMOND: rd_slot = slot_t'(base_diamond + int'(rd_index));
			default: begin
				rd_slot = '0;
				rd_hit = 1'b0;	// bg and hook have no table entry
			end
		endcase
	end

	assign rd_x = rd_hit ? tab_x[rd_slot] : '0;
	assign rd_y = rd_hit ? tab_y[rd_slot] : '0;

endmodule

// ==== hw/pixel_bus_master.sv ====
/* drains the painter pixel offers, lowest index first, into single Wishbone classic
   writes to video memory, pix_ready pulses back once the write is acked */
module pixel_bus_master import scene_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic [N_KINDS-1:0] pix_valid,
	input  pix_addr_t          pix_addr [N_KINDS],
	input  colour_t            pix_colour [N_KINDS],
	output logic [N_KINDS-1:0] pix_ready,
	output logic               wb_cyc,
	output logic               wb_stb,
	output logic               wb_we,
	output pix_addr_t          wb_adr,
	output colour_t            wb_dat_o,
	output logic               wb_sel,
	input  logic               wb_ack
);

	typedef logic [$clog2(N_KINDS)-1:0] idx_t;

	idx_t grant;	// painter owning the write on the bus
	idx_t pick;
	logic found;
	logic launch;

	always_comb begin
		found = 1'b0;
		pick = '0;
		for (int i = N_KINDS - 1; i >= 0; i--) begin
			if (pix_valid[i]) begin
				found = 1'b1;
				pick = idx_t'(i);
			end
		end
	end

	// the painter still shows the acked pixel while pix_ready is high
	assign launch = !wb_stb && found && (pix_ready == '0);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
			pix_ready <= '0;
		end else begin
			pix_ready <= '0;
			if (wb_stb && wb_ack) begin
				wb_cyc <= 1'b0;
				wb_stb <= 1'b0;
				wb_we <= 1'b0;
				pix_ready[grant] <= 1'b1;
			end else if (launch) begin
				wb_cyc <= 1'b1;
				wb_stb <= 1'b1;
				wb_we <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			grant <= pick;
			wb_adr <= pix_addr[pick];
			wb_dat_o <= pix_colour[pick];
		end
	end

	assign wb_sel = 1'b1;	// one byte lane

endmodule

// ==== hw/rect_painter.sv ====
/* walks one rectangle of its kind in raster order from the latched origin and offers
   each pixel to the bus master, one instance per object kind */
`include "scene_macros.svh"

module rect_painter import scene_pkg::*; #(
	parameter obj_kind_t kind = KIND_BG
) (
	input  logic      clk,
	input  logic      resetn,
	input  logic      start,
	input  coord_x_t  org_x,
	input  coord_y_t  org_y,
	output logic      done,
	output logic      pix_valid,
	output pix_addr_t pix_addr,
	output colour_t   pix_colour,
	input  logic      pix_ready
);

	localparam dim_t last_col = kind_width[kind] - dim_t'(1);
	localparam dim_t last_row = kind_height[kind] - dim_t'(1);

	coord_x_t ox;
	coord_y_t oy;
	dim_t     col;	// offset within the rectangle
	dim_t     row;
	coord_x_t x;
	coord_y_t y;
	logic     last_pix;
	logic     step;

	assign step = pix_valid && pix_ready;
	assign last_pix = (col == last_col) && (row == last_row);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pix_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				pix_valid <= 1'b1;
			end else if (step && last_pix) begin
				pix_valid <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			ox <= org_x;
			oy <= org_y;
			col <= '0;
			row <= '0;
		end else if (step) begin
			if (col == last_col) begin
				col <= '0;
				row <= row + dim_t'(1);
			end else begin
				col <= col + dim_t'(1);
			end
		end
	end

	assign x = ox + coord_x_t'(col);
	assign y = oy + coord_y_t'(row);
	assign pix_addr = pix_addr_t'(y) * pix_addr_t'(`SCREEN_W) + pix_addr_t'(x);
	assign pix_colour = kind_colour[kind];

endmodule

// ==== hw/scene_macros.svh ====
/* screen geometry, object counts and sprite sizes for the frame drawing subsystem,
   include wherever one of these values is needed */
`ifndef SCENE_MACROS_SVH
`define SCENE_MACROS_SVH

// screen in pixels, one word per pixel in video memory
`define SCREEN_W 32
`define SCREEN_H 24

// objects of each kind drawn per frame
`define N_GOLD    3
`define N_STONE   3
`define N_DIAMOND 2

// side length of each square sprite
`define GOLD_SIZE    4
`define STONE_SIZE   5
`define DIAMOND_SIZE 3
`define HOOK_SIZE    2

// placer lfsr start value, must not be zero
`define PLACE_SEED 16'hace1

`endif

// ==== hw/scene_pkg.sv ====
/* coordinate, colour and object kind types plus the per-kind size and colour tables,
   imported by every module of the frame drawing subsystem */
`include "scene_macros.svh"

package scene_pkg;

	typedef logic [4:0] coord_x_t;	// column
	typedef logic [4:0] coord_y_t;	// row
	typedef logic [9:0] pix_addr_t;	// row * SCREEN_W + column
	typedef logic [7:0] colour_t;
	typedef logic [5:0] dim_t;	// sprite width or height, up to the full screen

	// also the painter index
	typedef enum logic [2:0] {
		KIND_BG      = 3'd0,
		KIND_GOLD    = 3'd1,
		KIND_STONE   = 3'd2,
		KIND_DIAMOND = 3'd3,
		KIND_HOOK    = 3'd4
	} obj_kind_t;

	localparam int N_KINDS = 5;

	// background entry covers the whole screen
	localparam dim_t kind_width [N_KINDS] = '{
		dim_t'(`SCREEN_W), dim_t'(`GOLD_SIZE), dim_t'(`STONE_SIZE),
		dim_t'(`DIAMOND_SIZE), dim_t'(`HOOK_SIZE)
	};

	localparam dim_t kind_height [N_KINDS] = '{
		dim_t'(`SCREEN_H), dim_t'(`GOLD_SIZE), dim_t'(`STONE_SIZE),
		dim_t'(`DIAMOND_SIZE), dim_t'(`HOOK_SIZE)
	};

	// bg, gold, stone, diamond, hook
	localparam colour_t kind_colour [N_KINDS] = '{
		8'h12, 8'hfc, 8'h92, 8'h1f, 8'he0
	};

endpackage

// ==== hw/scene_sequencer.sv ====
/* frame level FSM, requests placement, then starts the painters one at a time in the
   order background, gold, stone, diamond, hook, and handles end of game */
`include "scene_macros.svh"

module scene_sequencer import scene_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic               go,
	input  logic               game_end,
	input  coord_x_t           hook_x,
	input  coord_y_t           hook_y,
	output logic               place_req,
	input  logic               place_done,
	output obj_kind_t          rd_kind,
	output logic [1:0]         rd_index,
	input  coord_x_t           rd_x,
	input  coord_y_t           rd_y,
	output logic [N_KINDS-1:0] paint_start,
	output coord_x_t           org_x,
	output coord_y_t           org_y,
	input  logic [N_KINDS-1:0] paint_done,
	output logic               frame_done
);

	typedef enum logic [3:0] {
		S_PLACE,
		S_BG,
		S_PICK,
		S_GOLD,
		S_STONE,
		S_DIAMOND,
		S_HOOK,
		S_FRAME_END,
		S_GAME_OVER
	} state_t;

	state_t     state;
	logic       busy;	// request issued, waiting for its done
	logic [1:0] cnt_gold;
	logic [1:0] cnt_stone;
	logic [1:0] cnt_diamond;

	assign frame_done = (state == S_FRAME_END);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= S_PLACE;
			busy <= 1'b0;
			place_req <= 1'b0;
			paint_start <= '0;
			cnt_gold <= '0;
			cnt_stone <= '0;
			cnt_diamond <= '0;
			rd_kind <= KIND_BG;
			rd_index <= '0;
		end else begin
			place_req <= 1'b0;
			paint_start <= '0;
			case (state)
				S_PLACE: begin
					if (!busy) begin
						place_req <= 1'b1;
						busy <= 1'b1;
					end else if (place_done) begin
						busy <= 1'b0;
						state <= S_BG;
					end
				end
				S_BG: begin
					if (!busy) begin
						paint_start[KIND_BG] <= 1'b1;
						org_x <= '0;
						org_y <= '0;
						busy <= 1'b1;
					end else if (paint_done[KIND_BG]) begin
						busy <= 1'b0;
						state <= S_PICK;
					end
				end
				S_PICK: begin
					// next object of the lowest kind still short of its count
					if (cnt_gold < `N_GOLD) begin
						rd_kind <= KIND_GOLD;
						rd_index <= cnt_gold;
						state <= S_GOLD;
					end else if (cnt_stone < `N_STONE) begin
						rd_kind <= KIND_STONE;
						rd_index <= cnt_stone;
						state <= S_STONE;
					end else if (cnt_diamond < `N_DIAMOND) begin
						rd_kind <= KIND_DIAMOND;
						rd_index <= cnt_diamond;
						state <= S_DIAMOND;
					end else begin
						state <= S_HOOK;
					end
				end
				S_GOLD, S_STONE, S_DIAMOND: begin
					if (!busy) begin
						paint_start[rd_kind] <= 1'b1;
						org_x <= rd_x;	// placer answers rd_kind/rd_index set in PICK
						org_y <= rd_y;
						busy <= 1'b1;
					end else if (paint_done[rd_kind]) begin
						busy <= 1'b0;
						state <= S_PICK;
						case (rd_kind)
							KIND_GOLD:  cnt_gold <= cnt_gold + 2'd1;
							KIND_STONE: cnt_stone <= cnt_stone + 2'd1;
							default:    cnt_diamond <= cnt_diamond + 2'd1;
						endcase
					end
				end
				S_HOOK: begin
					if (!busy) begin
						paint_start[KIND_HOOK] <= 1'b1;
						org_x <= hook_x;
						org_y <= hook_y;
						busy <= 1'b1;
					end else if (paint_done[KIND_HOOK]) begin
						busy <= 1'b0;
						state <= S_FRAME_END;
					end
				end
				S_FRAME_END: begin
					cnt_gold <= '0;
					cnt_stone <= '0;
					cnt_diamond <= '0;
					state <= game_end ? S_GAME_OVER : S_BG;
				end
				S_GAME_OVER: begin
					if (go)
						state <= S_PLACE;	// fresh positions for the new game
				end
				default: state <= S_PLACE;
			endcase
		end
	end

endmodule

// ==== project.f ====
+incdir+hw
hw/scene_pkg.sv
hw/object_placer.sv
hw/scene_sequencer.sv
hw/rect_painter.sv
hw/pixel_bus_master.sv
hw/game_view_top.sv
tests/tb_game_view.sv

// ==== run.sh ====
#!/bin/sh
# build and run the frame drawing testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_game_view -f project.f
out=$(./obj_dir/Vtb_game_view 2>&1) || true
echo "$out"
if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
else
	exit 1
fi

// ==== tests/tb_game_view.sv ====
/* testbench for game_view_top, acks writes after random delays and checks every
   Wishbone write of three frames against the drawing order model */
`include "scene_macros.svh"

module tb_game_view import scene_pkg::*; ();

	localparam int n_obj = `N_GOLD + `N_STONE + `N_DIAMOND;
	localparam int wait_limit = 400;	// cycles allowed for any single wait

	logic      clk;
	logic      resetn;
	logic      go;
	logic      game_end;
	coord_x_t  hook_x;
	coord_y_t  hook_y;
	logic      frame_done;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	pix_addr_t wb_adr;
	colour_t   wb_dat_o;
	logic      wb_sel;
	logic      wb_ack;

	logic [15:0] rng;
	logic        in_write;	// stb seen, write not yet retired
	logic [1:0]  ack_delay;
	pix_addr_t   held_adr;
	colour_t     held_dat;
	logic        placed;
	logic        hook_finished;
	logic        restarted;
	logic        end_game;
	logic [7:0]  pick;
	pix_addr_t   cur_org [n_obj];
	pix_addr_t   prev_org [n_obj];

	game_view_top dut_i (
		.clk        (clk),
		.resetn     (resetn),
		.go         (go),
		.game_end   (game_end),
		.hook_x     (hook_x),
		.hook_y     (hook_y),
		.frame_done (frame_done),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_o   (wb_dat_o),
		.wb_sel     (wb_sel),
		.wb_ack     (wb_ack)
	);

	always #10 clk = ~clk;

	// taps 16, 15, 13, 4
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
	endfunction

	task automatic rand_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			rng = lfsr_next(rng);
			v = {v[6:0], rng[0]};
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_addr(input string name, input pix_addr_t got, input pix_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic match_colour(input string name, input colour_t got, input colour_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERR t=%0t %s got %b expected %b", $time, name, got, exp));
	endtask

	function automatic int kind_count(input obj_kind_t kind);
		case (kind)
			KIND_GOLD:  return `N_GOLD;
			KIND_STONE: return `N_STONE;
			default:    return `N_DIAMOND;
		endcase
	endfunction

	task automatic new_hook();
		logic [7:0] r;
		rand_bits(5, r);
		hook_x = coord_x_t'(int'(r) % (`SCREEN_W - `HOOK_SIZE + 1));
		rand_bits(5, r);
		hook_y = coord_y_t'(int'(r) % (`SCREEN_H - `HOOK_SIZE + 1));
	endtask

	// wishbone slave model, called once per falling edge
	task automatic bus_step(output logic retired, output pix_addr_t a, output colour_t c);
		logic [7:0] r;
		retired = 1'b0;
		a = '0;
		c = '0;
		if (dut_i.place_done)
			placed = 1'b1;
		if (frame_done && !hook_finished)
			abort_run("frame_done pulsed before the hook rectangle was finished");
		if (wb_cyc && !placed)
			abort_run("bus cycle started before placement finished");
		expect_bit("wb_cyc", wb_cyc, wb_stb);
		if (wb_ack) begin
			wb_ack = 1'b0;	// master took the ack on the last rising edge
			expect_bit("wb_stb", wb_stb, 1'b0);
			in_write = 1'b0;
			retired = 1'b1;
			a = held_adr;
			c = held_dat;
		end else if (wb_stb) begin
			expect_bit("wb_we", wb_we, 1'b1);
			expect_bit("wb_sel", wb_sel, 1'b1);
			if (!in_write) begin
				in_write = 1'b1;
				held_adr = wb_adr;
				held_dat = wb_dat_o;
				rand_bits(2, r);
				ack_delay = r[1:0];
			end else begin
				compare_addr("wb_adr", wb_adr, held_adr);
				match_colour("wb_dat_o", wb_dat_o, held_dat);
			end
			if (ack_delay == 2'd0)
				wb_ack = 1'b1;
			else
				ack_delay = ack_delay - 2'd1;
		end
	endtask

	task automatic next_write(output pix_addr_t a, output colour_t c);
		logic retired;
		int   n;
		retired = 1'b0;
		n = 0;
		while (!retired) begin
			if (n == wait_limit)
				abort_run("timeout waiting for a Wishbone write to complete");
			@(negedge clk);
			bus_step(retired, a, c);
			n++;
		end
	endtask

	task automatic idle_step();
		logic      retired;
		pix_addr_t a;
		colour_t   c;
		@(negedge clk);
		bus_step(retired, a, c);
		if (retired)
			abort_run("Wishbone write retired where none was expected");
	endtask

	// first write gives the origin, the rest walk the rectangle
	task automatic paint_rect(input obj_kind_t kind, output pix_addr_t org);
		pix_addr_t a;
		colour_t   c;
		int        ox;
		int        oy;
		next_write(a, c);
		org = a;
		ox = int'(a) % `SCREEN_W;
		oy = int'(a) / `SCREEN_W;
		if (ox + int'(kind_width[kind]) > `SCREEN_W || oy + int'(kind_height[kind]) > `SCREEN_H)
			abort_run($sformatf("rectangle of kind %0d at %0d,%0d is off screen", kind, ox, oy));
		match_colour("wb_dat_o", c, kind_colour[kind]);
		for (int r = 0; r < int'(kind_height[kind]); r++) begin
			for (int k = 0; k < int'(kind_width[kind]); k++) begin
				if (r != 0 || k != 0) begin
					next_write(a, c);
					compare_addr("wb_adr", a, pix_addr_t'((oy + r) * `SCREEN_W + ox + k));
					match_colour("wb_dat_o", c, kind_colour[kind]);
				end
			end
		end
	endtask

	task automatic draw_frame(input logic restart, input logic first);
		pix_addr_t org;
		int        n;
		int        same;
		n = 0;
		same = 0;
		hook_finished = 1'b0;
		prev_org = cur_org;
		paint_rect(KIND_BG, org);
		compare_addr("background origin", org, '0);
		for (int k = KIND_GOLD; k <= KIND_DIAMOND; k++) begin
			for (int i = 0; i < kind_count(obj_kind_t'(k)); i++) begin
				paint_rect(obj_kind_t'(k), cur_org[n]);
				n++;
			end
		end
		paint_rect(KIND_HOOK, org);
		compare_addr("hook origin", org, pix_addr_t'(int'(hook_y) * `SCREEN_W + int'(hook_x)));
		hook_finished = 1'b1;
		for (int i = 0; i < n_obj; i++)
			if (cur_org[i] == prev_org[i])
				same++;
		if (restart && same == n_obj)
			abort_run("object origins did not change after the restart");
		if (!first && !restart && same != n_obj)
			abort_run("object origins changed without a new placement");
	endtask

	task automatic finish_frame(input logic stop_game);
		int n;
		n = 0;
		do begin
			if (n == wait_limit)
				abort_run("timeout waiting for frame_done after the hook");
			idle_step();
			n++;
		end while (frame_done !== 1'b1);
		hook_finished = 1'b0;	// a second pulse is an error
		game_end = stop_game;
		new_hook();
		idle_step();
		game_end = 1'b0;
	endtask

	task automatic restart_game();
		logic [7:0] r;
		rand_bits(3, r);
		for (int i = 0; i < int'(r) + 4; i++) begin
			idle_step();
			expect_bit("wb_cyc", wb_cyc, 1'b0);	// nothing drawn during game over
		end
		placed = 1'b0;
		go = 1'b1;
		idle_step();
		go = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		go = 1'b0;
		game_end = 1'b0;
		wb_ack = 1'b0;
		rng = 16'd60;
		in_write = 1'b0;
		ack_delay = '0;
		placed = 1'b0;
		hook_finished = 1'b0;
		restarted = 1'b0;
		new_hook();
		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			expect_bit("wb_cyc", wb_cyc, 1'b0);
			expect_bit("wb_stb", wb_stb, 1'b0);
			expect_bit("frame_done", frame_done, 1'b0);
		end
		resetn = 1'b1;
		for (int f = 0; f < 3; f++) begin
			draw_frame(restarted, f == 0);
			rand_bits(1, pick);
			end_game = (f == 0) || pick[0];	// first frame always covers the restart
			finish_frame(end_game);
			if (end_game && f < 2)
				restart_game();
			restarted = end_game;
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
